/* design/rvBusPkg.sv */
`default_nettype none

package rvBusPkg;

	localparam int XLen = 32;
	localparam int AddrW = 32;

	// Request slots offered by the memory unless the top level overrides it
	localparam int DefaultCredits = 2;

endpackage

`default_nettype wire

/* design/rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

	localparam int OpcodeW = 7;
	localparam int Funct3W = 3;
	localparam int RegAddrW = 5;

	// Base opcodes of the supported RV32I subset
	typedef enum logic [OpcodeW-1:0] {
		RType    = 7'b0110011,
		ITypeAlu = 7'b0010011,
		LwType   = 7'b0000011,
		SwType   = 7'b0100011,
		BType    = 7'b1100011,
		JalType  = 7'b1101111,
		LuiType  = 7'b0110111
	} opcodeT;

	typedef enum logic [2:0] {
		AluAdd = 3'b000,
		AluSub = 3'b001,
		AluAnd = 3'b010,
		AluOr  = 3'b011,
		AluSlt = 3'b101
	} aluCtrlT;

	// Operation class from the FSM, refined by funct bits in decode
	typedef enum logic [1:0] {AluOpAdd, AluOpSub, AluOpFunct} aluOpT;

	typedef enum logic [3:0] {
		Fetch, Decode, MemAdr, MemRead, MemWb, MemWrite,
		ExecuteR, ExecuteI, AluWb, BranchEq, JalJump, LuiWb
	} fsmStateT;

	typedef enum logic [1:0] {SrcAPc, SrcAOldPc, SrcAReg, SrcAZero} srcASelT;
	typedef enum logic [1:0] {SrcBReg, SrcBImm, SrcBFour} srcBSelT;
	typedef enum logic [1:0] {ResAluOut, ResData, ResAluResult} resultSelT;

endpackage

`default_nettype wire

/* design/coreMemIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface coreMemIf import rvBusPkg::*; ();

	logic start;             // One-cycle pulse, begins an access
	logic write;
	logic [AddrW-1:0] addr;
	logic [XLen-1:0] wdata;
	logic done;              // One-cycle pulse, access complete
	logic [XLen-1:0] rdata;

	// Control side issues accesses
	modport ctrl (output start, output write, input done);

	// Datapath side supplies address and store data
	modport data (output addr, output wdata, input rdata);

	// Bus master side
	modport port (
		input start, input write, input addr, input wdata,
		output done, output rdata
	);

endinterface

`default_nettype wire

/* design/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile import rvCorePkg::*, rvBusPkg::*; (
	input wire clk,
	input wire rst,
	input wire [RegAddrW-1:0] addr1,
	input wire [RegAddrW-1:0] addr2,
	input wire [RegAddrW-1:0] addr3,
	input wire regWrite,
	input wire [XLen-1:0] dataIn,
	output logic [XLen-1:0] rdData1,
	output logic [XLen-1:0] rdData2
);

	localparam int NumRegs = 1 << RegAddrW;

	logic [XLen-1:0] regs [NumRegs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && addr3 != '0) begin  // x0 stays zero
			regs[addr3] <= dataIn;
		end
	end

	assign rdData1 = (addr1 == '0) ? '0 : regs[addr1];
	assign rdData2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule

`default_nettype wire

/* design/controlFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module controlFsm import rvCorePkg::*; (
	input wire clk,
	input wire rst,
	input wire opcodeT opcode,
	input wire zero,
	coreMemIf.ctrl memCtrl,
	output logic irWrite,
	output logic pcUpdate,
	output logic branch,
	output logic regWrite,
	output logic adrSrc,
	output srcASelT srcASel,
	output srcBSelT srcBSel,
	output resultSelT resultSel,
	output aluOpT aluOpClass
);

	fsmStateT state, nextState;
	logic accessOpen;  // Set from start until done
	logic waitState;

	assign waitState = (state == Fetch) || (state == MemRead) || (state == MemWrite);
	assign memCtrl.start = waitState && !accessOpen;
	assign memCtrl.write = (state == MemWrite);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Fetch;
			accessOpen <= 1'b0;
		end else begin
			state <= nextState;
			if (memCtrl.done)
				accessOpen <= 1'b0;
			else if (memCtrl.start)
				accessOpen <= 1'b1;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			Fetch: if (memCtrl.done) nextState = Decode;
			Decode: begin
				case (opcode)
					LwType, SwType: nextState = MemAdr;
					RType: nextState = ExecuteR;
					ITypeAlu: nextState = ExecuteI;
					BType: nextState = BranchEq;
					JalType: nextState = JalJump;
					LuiType: nextState = LuiWb;
					default: nextState = Fetch;  // Unknown opcode is skipped
				endcase
			end
			MemAdr: nextState = (opcode == LwType) ? MemRead : MemWrite;
			MemRead: if (memCtrl.done) nextState = MemWb;
			MemWrite: if (memCtrl.done) nextState = Fetch;
			ExecuteR, ExecuteI, JalJump: nextState = AluWb;
			default: nextState = Fetch;
		endcase
	end

	always_comb begin
		irWrite = 1'b0;
		pcUpdate = 1'b0;
		branch = 1'b0;
		regWrite = 1'b0;
		adrSrc = 1'b0;
		srcASel = SrcAPc;
		srcBSel = SrcBFour;
		resultSel = ResAluResult;
		aluOpClass = AluOpAdd;
		case (state)
			Fetch: begin
				irWrite = memCtrl.done;   // Capture instruction and step PC
				pcUpdate = memCtrl.done;
			end
			Decode: begin
				srcASel = SrcAOldPc;  // Branch or jump target into ALU output
				srcBSel = SrcBImm;
			end
			MemAdr, MemRead, MemWrite: begin
				adrSrc = (state != MemAdr);
				srcASel = SrcAReg;     // Keeps the address steady while waiting
				srcBSel = SrcBImm;
			end
			MemWb: begin
				resultSel = ResData;
				regWrite = 1'b1;
			end
			ExecuteR, ExecuteI: begin
				srcASel = SrcAReg;
				srcBSel = (state == ExecuteR) ? SrcBReg : SrcBImm;
				aluOpClass = AluOpFunct;
			end
			AluWb: begin
				resultSel = ResAluOut;
				regWrite = 1'b1;
			end
			BranchEq: begin
				srcASel = SrcAReg;
				srcBSel = SrcBReg;
				aluOpClass = AluOpSub;
				resultSel = ResAluOut;
				branch = 1'b1;
			end
			JalJump: begin
				srcASel = SrcAOldPc;  // Return address for the following AluWb
				resultSel = ResAluOut;
				pcUpdate = 1'b1;
			end
			LuiWb: begin
				srcASel = SrcAZero;
				srcBSel = SrcBImm;
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end

	// One access at a time across the memory port
	assert property (@(posedge clk) disable iff (rst)
		memCtrl.start |=> (!memCtrl.start until memCtrl.done));

endmodule

`default_nettype wire

/* design/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode import rvCorePkg::*, rvBusPkg::*; (
	input wire clk,
	input wire rst,
	input wire [XLen-1:0] instr,
	input wire [XLen-1:0] resultData,
	input wire zero,
	coreMemIf.ctrl memCtrl,
	output logic [XLen-1:0] immExt,
	output aluCtrlT aluCtrl,
	output logic [XLen-1:0] srcA,
	output logic [XLen-1:0] srcB,
	output logic irWrite,
	output logic pcUpdate,
	output logic branch,
	output logic adrSrc,
	output srcASelT srcASel,
	output srcBSelT srcBSel,
	output resultSelT resultSel
);

	opcodeT opcode;
	aluOpT aluOpClass;
	logic regWrite;
	logic [RegAddrW-1:0] rd, rs1, rs2;
	logic [Funct3W-1:0] funct3;
	logic funct7b5;

	assign opcode = opcodeT'(instr[OpcodeW-1:0]);

	// Register and funct fields, zeroed where the format has none
	always_comb begin
		rd = instr[11:7];
		rs1 = instr[19:15];
		rs2 = instr[24:20];
		funct3 = instr[14:12];
		funct7b5 = 1'b0;
		case (opcode)
			RType: funct7b5 = instr[30];  // Only R-type selects sub this way
			ITypeAlu, LwType: rs2 = '0;
			SwType, BType: rd = '0;
			JalType, LuiType: begin
				rs1 = '0;
				rs2 = '0;
				funct3 = '0;
			end
			default: begin
				rd = '0;
				rs1 = '0;
				rs2 = '0;
				funct3 = '0;
			end
		endcase
	end

	always_comb begin
		case (opcode)
			ITypeAlu, LwType: immExt = {{20{instr[31]}}, instr[31:20]};
			SwType: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			BType: immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			JalType: immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			LuiType: immExt = {instr[31:12], 12'b0};  // Upper 20 bits
			default: immExt = '0;
		endcase
	end

	// ALU decoder
	always_comb begin
		aluCtrl = AluAdd;
		if (aluOpClass == AluOpSub) begin
			aluCtrl = AluSub;
		end else if (aluOpClass == AluOpFunct) begin
			case (funct3)
				3'b000: aluCtrl = funct7b5 ? AluSub : AluAdd;
				3'b010: aluCtrl = AluSlt;
				3'b110: aluCtrl = AluOr;
				3'b111: aluCtrl = AluAnd;
				default: aluCtrl = AluAdd;
			endcase
		end
	end

	controlFsm fsmInst (
		.clk(clk),
		.rst(rst),
		.opcode(opcode),
		.zero(zero),
		.memCtrl(memCtrl),
		.irWrite(irWrite),
		.pcUpdate(pcUpdate),
		.branch(branch),
		.regWrite(regWrite),
		.adrSrc(adrSrc),
		.srcASel(srcASel),
		.srcBSel(srcBSel),
		.resultSel(resultSel),
		.aluOpClass(aluOpClass)
	);

	registerFile regFileInst (
		.clk(clk),
		.rst(rst),
		.addr1(rs1),
		.addr2(rs2),
		.addr3(rd),
		.regWrite(regWrite),
		.dataIn(resultData),
		.rdData1(srcA),
		.rdData2(srcB)
	);

endmodule

`default_nettype wire

/* design/coreDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module coreDatapath import rvCorePkg::*, rvBusPkg::*; (
	input wire clk,
	input wire rst,
	input wire [XLen-1:0] rdData1,
	input wire [XLen-1:0] rdData2,
	input wire [XLen-1:0] immExt,
	input wire aluCtrlT aluCtrl,
	input wire irWrite,
	input wire pcUpdate,
	input wire branch,
	input wire adrSrc,
	input wire srcASelT srcASel,
	input wire srcBSelT srcBSel,
	input wire resultSelT resultSel,
	coreMemIf.data memData,
	output logic [XLen-1:0] instr,
	output logic [XLen-1:0] resultData,
	output logic zero
);

	logic [XLen-1:0] pc, oldPc, ir, dataReg, aReg, bReg, aluOut;
	logic [XLen-1:0] aluA, aluB, aluResult;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (pcUpdate || (branch && zero))
			pc <= resultData;
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (irWrite) begin
			ir <= memData.rdata;
			oldPc <= pc;
		end
		dataReg <= memData.rdata;  // Response data is held by the port
		aReg <= rdData1;
		bReg <= rdData2;
		aluOut <= aluResult;
	end

	always_comb begin
		case (srcASel)
			SrcAPc: aluA = pc;
			SrcAOldPc: aluA = oldPc;
			SrcAReg: aluA = aReg;
			default: aluA = '0;
		endcase
		case (srcBSel)
			SrcBReg: aluB = bReg;
			SrcBImm: aluB = immExt;
			SrcBFour: aluB = XLen'(4);
			default: aluB = '0;
		endcase
	end

	always_comb begin
		case (aluCtrl)
			AluSub: aluResult = aluA - aluB;
			AluAnd: aluResult = aluA & aluB;
			AluOr: aluResult = aluA | aluB;
			AluSlt: aluResult = {{(XLen-1){1'b0}}, $signed(aluA) < $signed(aluB)};
			default: aluResult = aluA + aluB;
		endcase
	end

	assign zero = (aluResult == '0);

	always_comb begin
		case (resultSel)
			ResAluOut: resultData = aluOut;
			ResData: resultData = dataReg;
			default: resultData = aluResult;
		endcase
	end

	assign instr = ir;
	assign memData.addr = adrSrc ? aluOut : pc;  // Data access or fetch
	assign memData.wdata = bReg;

endmodule

`default_nettype wire

/* design/memPort.sv */
`timescale 1ns/1ps
`default_nettype none

module memPort import rvBusPkg::*; #(
	parameter int MemCredits = DefaultCredits
) (
	input wire clk,
	input wire rst,
	coreMemIf.port core,
	output logic memReqValid,
	output logic memReqWrite,
	output logic [AddrW-1:0] memReqAddr,
	output logic [XLen-1:0] memReqData,
	input wire memRspValid,
	input wire [XLen-1:0] memRspData,
	input wire memCreditReturn
);

	localparam int CntW = $clog2(MemCredits + 1);

	logic [CntW-1:0] creditCnt;
	logic pending;  // Started but waiting for a credit
	logic sendNow;

	assign sendNow = (core.start || pending) && (creditCnt != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			creditCnt <= CntW'(MemCredits);
			pending <= 1'b0;
			memReqValid <= 1'b0;
			core.done <= 1'b0;
		end else begin
			creditCnt <= creditCnt - CntW'(sendNow) + CntW'(memCreditReturn);
			pending <= (core.start || pending) && !sendNow;
			memReqValid <= sendNow;
			core.done <= memRspValid;
		end
	end

	always_ff @(posedge clk) begin
		if (sendNow) begin
			memReqWrite <= core.write;
			memReqAddr <= core.addr;
			memReqData <= core.wdata;
		end
		if (memRspValid)
			core.rdata <= memRspData;
	end

	// Memory must not return more credits than it granted
	assert property (@(posedge clk) disable iff (rst) creditCnt <= MemCredits);

endmodule

`default_nettype wire

/* design/rvCoreTop.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreTop import rvCorePkg::*, rvBusPkg::*; #(
	parameter int MemCredits = DefaultCredits
) (
	input wire clk,
	input wire rst,
	output logic memReqValid,
	output logic memReqWrite,
	output logic [AddrW-1:0] memReqAddr,
	output logic [XLen-1:0] memReqData,
	input wire memRspValid,
	input wire [XLen-1:0] memRspData,
	input wire memCreditReturn
);

	coreMemIf memIf ();

	logic [XLen-1:0] instr, resultData, immExt, rdData1, rdData2;
	logic zero, irWrite, pcUpdate, branch, adrSrc;
	aluCtrlT aluCtrl;
	srcASelT srcASel;
	srcBSelT srcBSel;
	resultSelT resultSel;

	instrDecode decodeInst (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.resultData(resultData),
		.zero(zero),
		.memCtrl(memIf),
		.immExt(immExt),
		.aluCtrl(aluCtrl),
		.srcA(rdData1),
		.srcB(rdData2),
		.irWrite(irWrite),
		.pcUpdate(pcUpdate),
		.branch(branch),
		.adrSrc(adrSrc),
		.srcASel(srcASel),
		.srcBSel(srcBSel),
		.resultSel(resultSel)
	);

	coreDatapath datapathInst (
		.clk(clk),
		.rst(rst),
		.rdData1(rdData1),
		.rdData2(rdData2),
		.immExt(immExt),
		.aluCtrl(aluCtrl),
		.irWrite(irWrite),
		.pcUpdate(pcUpdate),
		.branch(branch),
		.adrSrc(adrSrc),
		.srcASel(srcASel),
		.srcBSel(srcBSel),
		.resultSel(resultSel),
		.memData(memIf),
		.instr(instr),
		.resultData(resultData),
		.zero(zero)
	);

	memPort #(
		.MemCredits(MemCredits)
	) memPortInst (
		.clk(clk),
		.rst(rst),
		.core(memIf),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memReqData(memReqData),
		.memRspValid(memRspValid),
		.memRspData(memRspData),
		.memCreditReturn(memCreditReturn)
	);

endmodule

`default_nettype wire

/* verification/memModel.sv */
`timescale 1ns/1ps
`default_nettype none

module memModel import rvBusPkg::*; #(
	parameter int Words = 1024
) (
	input wire clk,
	input wire rst,
	input wire memReqValid,
	input wire memReqWrite,
	input wire [AddrW-1:0] memReqAddr,
	input wire [XLen-1:0] memReqData,
	output logic memRspValid,
	output logic [XLen-1:0] memRspData,
	output logic memCreditReturn,
	input wire [1:0] rspDelay,     // Drawn fresh every cycle
	input wire [1:0] creditDelay,
	input wire [7:0] creditExtra   // Extra hold added to every credit
);

	localparam int IdxW = $clog2(Words);

	logic [XLen-1:0] mem [Words];
	logic rspValidQ = 1'b0;
	logic [XLen-1:0] rspDataQ = '0;
	logic creditQ = 1'b0;
	logic [IdxW-1:0] idx;
	int cycle;
	int rspDue [$];
	logic [XLen-1:0] rspWord [$];
	int creditDue [$];

	assign memRspValid = rspValidQ;
	assign memRspData = rspDataQ;
	assign memCreditReturn = creditQ;

	always @(posedge clk) begin
		rspValidQ <= 1'b0;
		creditQ <= 1'b0;
		if (rst) begin
			cycle = 0;
			rspDue.delete();
			rspWord.delete();
			creditDue.delete();  // Credits in flight are dropped with the core's count
		end else begin
			if (memReqValid) begin
				idx = memReqAddr[IdxW+1:2];
				if (memReqWrite)
					mem[idx] = memReqData;  // Visible to later reads at once
				rspDue.push_back(cycle + int'(rspDelay));
				rspWord.push_back(mem[idx]);
				creditDue.push_back(cycle + int'(creditDelay) + int'(creditExtra));
			end
			// At most one response and one credit per cycle, in request order
			if (rspDue.size() > 0 && rspDue[0] <= cycle) begin
				rspValidQ <= 1'b1;
				rspDataQ <= rspWord.pop_front();
				void'(rspDue.pop_front());
			end
			if (creditDue.size() > 0 && creditDue[0] <= cycle) begin
				creditQ <= 1'b1;
				void'(creditDue.pop_front());
			end
			cycle++;
		end
	end

endmodule

`default_nettype wire

/* verification/rvCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb import rvBusPkg::*; ();

	localparam int Credits = DefaultCredits;
	localparam int MemWords = 1024;
	localparam int IdxW = $clog2(MemWords);
	localparam int MarkerAddr = 'h100;
	localparam int OpImm = 'h13;
	localparam int OpLoad = 'h03;
	localparam int CyclesPerInstr = 40;

	logic clk;
	logic rst;
	logic memReqValid, memReqWrite;
	logic [AddrW-1:0] memReqAddr;
	logic [XLen-1:0] memReqData;
	logic memRspValid, memCreditReturn;
	logic [XLen-1:0] memRspData;
	logic [1:0] rspDelay = 2'd0;
	logic [1:0] creditDelay = 2'd0;
	logic [7:0] creditExtra;

	logic [31:0] lfsr = 32'd98504;
	logic [3:0] delayBits;
	logic markerSeen;
	int outstanding;
	int limitHits = 0;
	int valueErrors = 0;
	int protocolErrors = 0;
	int otherErrors = 0;
	int cycleCount = 0;
	int deadline = 10;
	string testName = "startup";

	logic [31:0] prog [$];
	int preAddr [$];
	logic [31:0] preVal [$];
	int expAddr [$];
	logic [31:0] expVal [$];

	rvCoreTop #(
		.MemCredits(Credits)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memReqData(memReqData),
		.memRspValid(memRspValid),
		.memRspData(memRspData),
		.memCreditReturn(memCreditReturn)
	);

	memModel #(
		.Words(MemWords)
	) memInst (
		.clk(clk),
		.rst(rst),
		.memReqValid(memReqValid),
		.memReqWrite(memReqWrite),
		.memReqAddr(memReqAddr),
		.memReqData(memReqData),
		.memRspValid(memRspValid),
		.memRspData(memRspData),
		.memCreditReturn(memCreditReturn),
		.rspDelay(rspDelay),
		.creditDelay(creditDelay),
		.creditExtra(creditExtra)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	always @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			lfsr = lfsrStep(lfsr);
			delayBits[i] = lfsr[0];
		end
		rspDelay <= delayBits[1:0];
		creditDelay <= delayBits[3:2];
	end

	// Bus monitor with its own count of requests holding a credit
	always @(posedge clk) begin
		if (rst) begin
			outstanding <= 0;
			markerSeen <= 1'b0;
		end else begin
			if (memReqValid && outstanding >= Credits) begin
				$display("Request sent at %0t while all %0d credits were in use", $time, Credits);
				protocolErrors++;
			end
			if (outstanding == Credits)
				limitHits++;
			if (memReqValid && memReqWrite && memReqAddr == AddrW'(MarkerAddr))
				markerSeen <= 1'b1;
			outstanding <= outstanding + int'(memReqValid) - int'(memCreditReturn);
		end
	end

	function automatic logic [31:0] encR(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(int op, int rd, int f3, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] encS(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(int rs1, int rs2, int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(int rd, int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic logic [31:0] encU(int rd, int imm);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	// Differing sign bits decide alone and equal ones compare unsigned
	function automatic logic [31:0] signedLess(logic [31:0] x, logic [31:0] y);
		if (x[31] != y[31])
			return {31'b0, x[31]};
		return {31'b0, x < y};
	endfunction

	function automatic logic [31:0] fillWord(int addr);
		return 32'hDEAD0000 ^ addr;
	endfunction

	function automatic logic [IdxW-1:0] wordIndex(int addr);
		return addr[IdxW+1:2];
	endfunction

	task automatic pushInstr(logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic expectWord(int addr, logic [31:0] val);
		expAddr.push_back(addr);
		expVal.push_back(val);
	endtask

	task automatic storeAndExpect(int rs2, int addr, logic [31:0] val);
		pushInstr(encS(rs2, 0, addr));
		expectWord(addr, val);
	endtask

	task automatic preloadWord(int addr, logic [31:0] val);
		preAddr.push_back(addr);
		preVal.push_back(val);
	endtask

	task automatic checkEqual(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic loadMemory();
		for (int a = 0; a < MemWords * 4; a += 4)
			memInst.mem[wordIndex(a)] = fillWord(a);
		foreach (prog[i])
			memInst.mem[wordIndex(i * 4)] = prog[i];
		foreach (preAddr[i])
			memInst.mem[wordIndex(preAddr[i])] = preVal[i];
	endtask

	// Memory is loaded while the core is held in reset
	task automatic startProgram();
		@(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		loadMemory();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic runProgram(string name);
		logic [31:0] got;
		testName = name;
		pushInstr(encS(0, 0, MarkerAddr));  // End marker
		pushInstr(encJ(0, 0));              // Park on itself
		deadline += prog.size() * CyclesPerInstr + 10;
		startProgram();
		while (!markerSeen)
			@(posedge clk);
		foreach (expAddr[i]) begin
			got = memInst.mem[wordIndex(expAddr[i])];
			checkEqual($sformatf("%s mem[%h]", name, expAddr[i]), expVal[i], got);
		end
		prog.delete();
		preAddr.delete();
		preVal.delete();
		expAddr.delete();
		expVal.delete();
	endtask

	task automatic testAlu();
		logic [31:0] a, b;
		a = 25;
		b = -7;
		pushInstr(encI(OpImm, 1, 0, 0, 25));       // addi x1, x0, 25
		pushInstr(encI(OpImm, 2, 0, 0, -7));
		pushInstr(encR(0, 2, 1, 0, 3));            // add x3, x1, x2
		pushInstr(encR('h20, 2, 1, 0, 4));         // sub x4, x1, x2
		pushInstr(encR(0, 2, 1, 7, 5));
		pushInstr(encR(0, 2, 1, 6, 6));
		pushInstr(encR(0, 1, 2, 2, 7));            // slt x7, x2, x1
		pushInstr(encR(0, 2, 1, 2, 8));
		pushInstr(encI(OpImm, 9, 7, 1, -16));      // andi
		pushInstr(encI(OpImm, 10, 6, 2, 'h100));   // ori
		pushInstr(encI(OpImm, 11, 2, 2, -3));      // slti
		pushInstr(encI(OpImm, 12, 2, 1, 5));
		pushInstr(encI(OpImm, 13, 0, 2, -2048));
		storeAndExpect(3, 'h200, a + b);
		storeAndExpect(4, 'h204, a - b);
		storeAndExpect(5, 'h208, a & b);
		storeAndExpect(6, 'h20C, a | b);
		storeAndExpect(7, 'h210, signedLess(b, a));
		storeAndExpect(8, 'h214, signedLess(a, b));
		storeAndExpect(9, 'h218, a & 32'hFFFFFFF0);
		storeAndExpect(10, 'h21C, b | 32'h100);
		storeAndExpect(11, 'h220, signedLess(b, -3));
		storeAndExpect(12, 'h224, signedLess(a, 5));
		storeAndExpect(13, 'h228, b + 32'hFFFFF800);
		runProgram("alu");
	endtask

	task automatic testMemory();
		preloadWord('h300, 32'hCAFE1234);
		preloadWord('h304, 32'h0BADF00D);
		pushInstr(encI(OpLoad, 1, 2, 0, 'h300));   // lw x1, 0x300(x0)
		storeAndExpect(1, 'h240, 32'hCAFE1234);
		pushInstr(encI(OpImm, 0, 0, 0, 55));       // Writes to x0 are lost
		pushInstr(encI(OpLoad, 0, 2, 0, 'h304));
		pushInstr(encR(0, 0, 0, 0, 2));
		storeAndExpect(0, 'h244, 0);
		storeAndExpect(2, 'h248, 0);
		pushInstr(encI(OpImm, 3, 0, 0, 'h308));
		pushInstr(encI(OpLoad, 4, 2, 3, -4));      // lw x4, -4(x3)
		pushInstr(encS(4, 3, -'h80));              // sw x4, -0x80(x3)
		expectWord('h288, 32'h0BADF00D);
		runProgram("memory");
	endtask

	task automatic testControl();
		int jalPc;
		pushInstr(encI(OpImm, 1, 0, 0, 5));
		pushInstr(encI(OpImm, 2, 0, 0, 5));
		pushInstr(encI(OpImm, 3, 0, 0, 9));
		pushInstr(encI(OpImm, 5, 0, 0, 'h77));
		pushInstr(encB(1, 2, 8));                  // Taken so the store is skipped
		pushInstr(encS(5, 0, 'h260));
		expectWord('h260, fillWord('h260));
		pushInstr(encB(1, 3, 8));                  // Not taken
		storeAndExpect(5, 'h264, 'h77);
		jalPc = prog.size() * 4;
		pushInstr(encJ(6, 8));
		pushInstr(encS(5, 0, 'h268));
		expectWord('h268, fillWord('h268));
		storeAndExpect(6, 'h26C, jalPc + 4);       // Return address
		runProgram("control");
	endtask

	task automatic testLui();
		pushInstr(encU(1, 'h12345));
		pushInstr(encU(2, 'hFEDCB));
		pushInstr(encI(OpImm, 3, 0, 2, 'h7FF));
		storeAndExpect(1, 'h280, 32'h12345 << 12);
		storeAndExpect(2, 'h284, 32'hFEDCB << 12);
		storeAndExpect(3, 'h28C, (32'hFEDCB << 12) + 32'h7FF);
		runProgram("lui");
	endtask

	task automatic testBackPressure();
		int hitsBefore;
		hitsBefore = limitHits;
		creditExtra <= 8'd16;  // Credits come back slowly
		preloadWord('h300, 32'h13579BDF);
		pushInstr(encI(OpLoad, 1, 2, 0, 'h300));
		pushInstr(encI(OpImm, 2, 0, 1, 1));
		pushInstr(encR('h20, 1, 2, 0, 3));         // sub x3, x2, x1
		storeAndExpect(1, 'h2A0, 32'h13579BDF);
		storeAndExpect(2, 'h2A4, 32'h13579BE0);
		storeAndExpect(3, 'h2A8, 1);
		pushInstr(encI(OpLoad, 4, 2, 0, 'h2A4));
		storeAndExpect(4, 'h2AC, 32'h13579BE0);
		runProgram("backpressure");
		creditExtra <= 8'd0;
		if (limitHits == hitsBefore) begin
			$display("Back-pressure test never used up all credits");
			otherErrors++;
		end
	endtask

	task automatic finishRun(bit timedOut);
		$display("Errors: %0d value, %0d protocol, %0d other, timeout %0d",
			valueErrors, protocolErrors, otherErrors, timedOut);
		if (!timedOut && valueErrors == 0 && protocolErrors == 0 && otherErrors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	initial begin : watchdog
		while (cycleCount <= deadline) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: test %s did not reach its end marker by cycle %0d",
			testName, cycleCount);
		finishRun(1'b1);
	end

	initial begin
		rst = 1'b1;
		creditExtra = 8'd0;
		testAlu();
		testMemory();
		testControl();
		testLui();
		testBackPressure();
		finishRun(1'b0);
	end

endmodule

`default_nettype wire

/* flist.f */
design/rvBusPkg.sv
design/rvCorePkg.sv
design/coreMemIf.sv
design/registerFile.sv
design/controlFsm.sv
design/instrDecode.sv
design/coreDatapath.sv
design/memPort.sv
design/rvCoreTop.sv
verification/memModel.sv
verification/rvCoreTb.sv

/* Makefile */
TOP := rvCoreTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f flist.f

# Status comes from the search for the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf obj_dir
